// File: source/rp_analog_pkg.sv
////////////////////////////////////////
// sizes for the 14-bit ADC/DAC board; channel pairs are ch_a/ch_b
// DAC words here are raw codes, inverted slope
////////////////////////////////////////

`default_nettype none

package rp_analog_pkg;

  ////////////////////////////////////////
  // widths and counts
  ////////////////////////////////////////

  localparam int ADC_DW       = 14;                     // adc word
  localparam int ACQ_DW       = 12;                     // upper bits sent to acquisition
  localparam int DAC_DW       = 14;
  localparam int SUM_DW       = DAC_DW + 1;             // one guard bit
  localparam int RST_HOLD     = 64;                     // good cycles before release
  localparam int RST_CW       = $clog2(RST_HOLD + 1);
  localparam int DAISY_DW     = 16;
  localparam int DAISY_MODE_W = 3;

  localparam logic [RST_CW-1:0] RST_HOLD_C = RST_CW'(RST_HOLD);

  // dac code limits
  localparam int                DAC_FS      = 2 ** (DAC_DW - 1);
  localparam logic [DAC_DW-1:0] DAC_SAT_POS = {1'b0, {(DAC_DW-1){1'b1}}};  // positive overflow
  localparam logic [DAC_DW-1:0] DAC_SAT_NEG = {1'b1, {(DAC_DW-1){1'b0}}};  // negative overflow

  ////////////////////////////////////////
  // channel pairs
  ////////////////////////////////////////

  typedef struct packed {
    logic [ADC_DW-1:0] ch_a;
    logic [ADC_DW-1:0] ch_b;
  } adc_pair_t;

  typedef struct packed {
    logic [ACQ_DW-1:0] ch_a;
    logic [ACQ_DW-1:0] ch_b;
  } acq_pair_t;

  // generator, controller and dac code pairs
  typedef struct packed {
    logic signed [DAC_DW-1:0] ch_a;
    logic signed [DAC_DW-1:0] ch_b;
  } smp_pair_t;

  // mixer sum, read as a value or as range check plus body
  // range[0] is also the dac msb, so the dac body is {range[0], body}
  typedef union packed {
    logic signed [SUM_DW-1:0] val;
    struct packed {
      logic [1:0]        range;  // differ on overflow
      logic [SUM_DW-3:0] body;
    } fld;
  } dac_sum_u;

  typedef struct packed {
    logic out_sel;   // trigger out: 1 generator, 0 scope
    logic pad_mode;  // reserved
    logic sync;      // daisy sync mode
  } daisy_mode_t;

endpackage

`default_nettype wire

// File: source/core_reset_seq.sv
////////////////////////////////////////
// core reset held low until lock, delay-ready and cpu reset are all
// good for RST_HOLD cycles; any drop restarts the count
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module core_reset_seq (
  input  wire  adc_clk,
  input  wire  rst_n_i,       // processor reset
  input  wire  pll_locked_i,
  input  wire  idly_rdy_i,    // input delay calibrated
  output logic rstn_o,        // core reset, active low
  output logic dac_reset_o    // active high
);

  logic                             all_ok;
  logic [rp_analog_pkg::RST_CW-1:0] hold_cnt;

  assign all_ok = rst_n_i & pll_locked_i & idly_rdy_i;

  ////////////////////////////////////////
  // hold counter
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!all_ok) begin
      hold_cnt <= '0;    // restart on any missing input
      rstn_o   <= 1'b0;
    end else begin
      if (hold_cnt != rp_analog_pkg::RST_HOLD_C) begin
        hold_cnt <= hold_cnt + 1'b1;
      end
      rstn_o <= (hold_cnt == rp_analog_pkg::RST_HOLD_C);  // release edge after full count
    end
  end

  // dac reset trails the core reset by one cycle
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_reset_o <= 1'b1;
    end else begin
      dac_reset_o <= ~rstn_o;
    end
  end

  // lock loss pulls the core into reset on the next edge
  a_lock_drop: assert property (@(posedge adc_clk) !pll_locked_i |=> !rstn_o);

endmodule

`default_nettype wire

// File: source/adc_frontend.sv
////////////////////////////////////////
// plain capture register stands in for the ddr input stage
// loopback takes the unsaturated sum, not the dac code
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module adc_frontend (
  input  wire                               adc_clk,
  input  wire                               rst_n_i,
  input  wire rp_analog_pkg::adc_pair_t     adc_dat_i,
  input  wire rp_analog_pkg::dac_sum_u [1:0] dac_sum_i,       // ch_a at [0] and ch_b at [1]
  input  wire                               digital_loop_i,  // strap that routes dac sums to acq
  input  wire                               trig_i,          // external trigger pin
  input  wire                               scope_trig_i,
  input  wire                               asg_trig_i,
  input  wire rp_analog_pkg::daisy_mode_t   daisy_mode_i,
  input  wire [rp_analog_pkg::DAISY_DW-1:0] daisy_dat_i,     // received daisy word
  output rp_analog_pkg::acq_pair_t          acq_o,
  output logic                              trig_ext_o,
  output logic                              trig_out_o
);

  rp_analog_pkg::adc_pair_t adc_q;      // capture stage
  logic                     daisy_act;  // daisy word seen last cycle

  ////////////////////////////////////////
  // capture and switch
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    adc_q <= adc_dat_i;
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      acq_o <= '0;
    end else if (digital_loop_i) begin
      // same channel from the upper bits of the dac-width part
      acq_o.ch_a <= dac_sum_i[0].val[rp_analog_pkg::DAC_DW-1 -: rp_analog_pkg::ACQ_DW];
      acq_o.ch_b <= dac_sum_i[1].val[rp_analog_pkg::DAC_DW-1 -: rp_analog_pkg::ACQ_DW];
    end else begin
      acq_o.ch_a <= adc_q.ch_b[rp_analog_pkg::ADC_DW-1 -: rp_analog_pkg::ACQ_DW];  // adc b -> ch a
      acq_o.ch_b <= adc_q.ch_a[rp_analog_pkg::ADC_DW-1 -: rp_analog_pkg::ACQ_DW];  // adc a -> ch b
    end
  end

  ////////////////////////////////////////
  // triggers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      daisy_act <= 1'b0;
    end else begin
      daisy_act <= |daisy_dat_i;
    end
  end

  // in sync mode the chain owns the trigger while it carries data
  assign trig_ext_o = trig_i & ~(daisy_mode_i.sync & daisy_act);
  assign trig_out_o = daisy_mode_i.out_sel ? asg_trig_i : scope_trig_i;

endmodule

`default_nettype wire

// File: source/dac_mixer.sv
////////////////////////////////////////
// gen + pid per channel, saturated to the dac range
// code out is inverted slope, one register after the sum
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dac_mixer (
  input  wire                             adc_clk,
  input  wire                             rst_n_i,
  input  wire rp_analog_pkg::smp_pair_t   gen_i,   // generator samples
  input  wire rp_analog_pkg::smp_pair_t   pid_i,   // controller samples
  output rp_analog_pkg::dac_sum_u [1:0]   sum_o,   // unsaturated, [0] ch_a
  output rp_analog_pkg::smp_pair_t        code_o
);

  // sign extend both by one bit, then add
  function automatic rp_analog_pkg::dac_sum_u add_f(
    input logic signed [rp_analog_pkg::DAC_DW-1:0] a,
    input logic signed [rp_analog_pkg::DAC_DW-1:0] b
  );
    rp_analog_pkg::dac_sum_u s;
    s.val = $signed({a[rp_analog_pkg::DAC_DW-1], a}) + $signed({b[rp_analog_pkg::DAC_DW-1], b});
    return s;
  endfunction

  function automatic logic [rp_analog_pkg::DAC_DW-1:0] code_f(
    input rp_analog_pkg::dac_sum_u s
  );
    logic [rp_analog_pkg::DAC_DW-1:0] c;
    if (s.fld.range[1] != s.fld.range[0]) begin
      // sign bit tells the overflow direction
      c = s.fld.range[1] ? rp_analog_pkg::DAC_SAT_NEG : rp_analog_pkg::DAC_SAT_POS;
    end else begin
      c = ~{s.fld.range[0], s.fld.body};  // dac wants inverted code
    end
    return c;
  endfunction

  always_comb begin
    sum_o[0] = add_f(gen_i.ch_a, pid_i.ch_a);
    sum_o[1] = add_f(gen_i.ch_b, pid_i.ch_b);
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      code_o <= '0;
    end else begin
      code_o.ch_a <= code_f(sum_o[0]);
      code_o.ch_b <= code_f(sum_o[1]);
    end
  end

  // a saturated code only follows a sum at or beyond full scale
  property p_sat_src(code, s);
    @(posedge adc_clk) disable iff (!rst_n_i)
      (code == rp_analog_pkg::DAC_SAT_POS || code == rp_analog_pkg::DAC_SAT_NEG)
        |-> $past(s >= rp_analog_pkg::DAC_FS - 1 || s <= -rp_analog_pkg::DAC_FS);
  endproperty

  a_sat_a: assert property (p_sat_src(code_o.ch_a, sum_o[0].val));
  a_sat_b: assert property (p_sat_src(code_o.ch_b, sum_o[1].val));

endmodule

`default_nettype wire

// File: source/dac_backend.sv
////////////////////////////////////////
// pin register, channels swapped to match board routing
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dac_backend (
  input  wire                           adc_clk,
  input  wire                           rst_n_i,
  input  wire rp_analog_pkg::smp_pair_t code_i,     // inverted dac codes
  output rp_analog_pkg::smp_pair_t      dac_dat_o   // to the dac pins
);

  ////////////////////////////////////////
  // output stage
  ////////////////////////////////////////

  // separate stage so the pins see a flop close to the pads
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_dat_o <= '0;
    end else begin
      dac_dat_o.ch_a <= code_i.ch_b;  // ch b -> dac a
      dac_dat_o.ch_b <= code_i.ch_a;  // ch a -> dac b
    end
  end

endmodule

`default_nettype wire

// File: source/rp_analog_top.sv
////////////////////////////////////////
// analog path top, single adc_clk domain
// all blocks run from the sequenced core reset
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rp_analog_top (
  input  wire                               adc_clk,
  input  wire                               rst_n_i,         // processor reset
  input  wire                               pll_locked_i,
  input  wire                               idly_rdy_i,
  input  wire rp_analog_pkg::adc_pair_t     adc_dat_i,
  input  wire rp_analog_pkg::smp_pair_t     gen_i,
  input  wire rp_analog_pkg::smp_pair_t     pid_i,
  input  wire                               digital_loop_i,
  input  wire                               trig_i,
  input  wire                               scope_trig_i,
  input  wire                               asg_trig_i,
  input  wire rp_analog_pkg::daisy_mode_t   daisy_mode_i,
  input  wire [rp_analog_pkg::DAISY_DW-1:0] daisy_dat_i,
  output rp_analog_pkg::acq_pair_t          acq_o,
  output rp_analog_pkg::smp_pair_t          dac_dat_o,
  output logic                              dac_reset_o,
  output logic                              trig_ext_o,
  output logic                              trig_out_o
);

  logic                          core_rstn;
  rp_analog_pkg::dac_sum_u [1:0] dac_sum;    // loopback source
  rp_analog_pkg::smp_pair_t      dac_code;

  core_reset_seq u_rst (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .pll_locked_i (pll_locked_i),
    .idly_rdy_i   (idly_rdy_i),
    .rstn_o       (core_rstn),
    .dac_reset_o  (dac_reset_o)
  );

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////

  adc_frontend u_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (core_rstn),
    .adc_dat_i      (adc_dat_i),
    .dac_sum_i      (dac_sum),
    .digital_loop_i (digital_loop_i),
    .trig_i         (trig_i),
    .scope_trig_i   (scope_trig_i),
    .asg_trig_i     (asg_trig_i),
    .daisy_mode_i   (daisy_mode_i),
    .daisy_dat_i    (daisy_dat_i),
    .acq_o          (acq_o),
    .trig_ext_o     (trig_ext_o),
    .trig_out_o     (trig_out_o)
  );

  ////////////////////////////////////////
  // output side
  ////////////////////////////////////////

  dac_mixer u_mix (
    .adc_clk (adc_clk),
    .rst_n_i (core_rstn),
    .gen_i   (gen_i),
    .pid_i   (pid_i),
    .sum_o   (dac_sum),
    .code_o  (dac_code)
  );

  dac_backend u_dac (
    .adc_clk   (adc_clk),
    .rst_n_i   (core_rstn),
    .code_i    (dac_code),
    .dac_dat_o (dac_dat_o)
  );

endmodule

`default_nettype wire

// File: verif/tb_checker.sv
////////////////////////////////////////
// samples on the falling edge and checks each row two cycles after it
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  wire                               adc_clk,
  input  wire                               rst_n_i,
  input  wire                               row_vld_i,
  input  wire [8*12-1:0]                    row_name_i,
  input  wire rp_analog_pkg::adc_pair_t     adc_dat_i,
  input  wire rp_analog_pkg::smp_pair_t     gen_i,
  input  wire rp_analog_pkg::smp_pair_t     pid_i,
  input  wire                               digital_loop_i,
  input  wire                               trig_i,
  input  wire                               scope_trig_i,
  input  wire                               asg_trig_i,
  input  wire rp_analog_pkg::daisy_mode_t   daisy_mode_i,
  input  wire [rp_analog_pkg::DAISY_DW-1:0] daisy_dat_i,
  input  wire rp_analog_pkg::acq_pair_t     acq_i,
  input  wire rp_analog_pkg::smp_pair_t     dac_dat_i,
  input  wire                               dac_reset_i,
  input  wire                               trig_ext_i,
  input  wire                               trig_out_i,
  output int                                n_tests_o,
  output int                                n_fail_o,
  output int                                n_err_o
);

  typedef struct packed {
    logic                       vld;
    logic [8*12-1:0]            name;
    rp_analog_pkg::adc_pair_t   adc;
    rp_analog_pkg::smp_pair_t   gen;
    rp_analog_pkg::smp_pair_t   pid;
    logic                       loop;
    logic                       trig;
    logic                       scope;
    logic                       asg;
    rp_analog_pkg::daisy_mode_t mode;
    logic                       daisy_nz;
    rp_analog_pkg::acq_pair_t   acq;
    logic                       trig_ext;
    logic                       trig_out;
  } snap_t;

  snap_t h [4];    // [0] this cycle and [3] three cycles back
  int    rst_cyc;  // falling edges seen in reset
  int    run_cyc;  // falling edges since release with dac reset high
  int    cur_err;  // errors of the test in progress
  logic  rst_done;

  initial begin
    n_tests_o = 0;
    n_fail_o  = 0;
    n_err_o   = 0;
    rst_cyc   = 0;
    run_cyc   = 0;
    cur_err   = 0;
    rst_done  = 1'b0;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic int sum_f(input logic signed [13:0] a, input logic signed [13:0] b);
    return int'(a) + int'(b);
  endfunction

  // saturate or invert the two's complement
  function automatic logic [13:0] code_f(input int s);
    if (s > rp_analog_pkg::DAC_FS - 1) return 14'h1fff;
    if (s < -rp_analog_pkg::DAC_FS) return 14'h2000;
    return ~s[13:0];
  endfunction

  task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %0t %s got %h expected %h", $time, sig, got, exp);
      n_err_o++;
      cur_err++;
    end
  endtask

  task automatic report_test(input logic [8*12-1:0] name);
    $display("test %0d %s %s", n_tests_o, name, (cur_err == 0) ? "ok" : "with errors");
    n_tests_o++;
    if (cur_err != 0) n_fail_o++;
    cur_err = 0;
  endtask

  task automatic check_reset();
    if (!rst_n_i) begin
      rst_cyc++;
      if (rst_cyc >= 2) begin  // first edge has cleared the pipe
        check_val("dac_reset_o", dac_reset_i, 1);
        check_val("acq_o", acq_i, 0);
        check_val("dac_dat_o", dac_dat_i, 0);
      end
    end else if (!rst_done && rst_cyc > 0) begin
      if (dac_reset_i) begin
        check_val("acq_o", acq_i, 0);       // core still held
        check_val("dac_dat_o", dac_dat_i, 0);
        run_cyc++;
      end else begin
        if (run_cyc != rp_analog_pkg::RST_HOLD + 2) begin
          $display("dac reset fell %0d cycles after reset release, expected %0d",
                   run_cyc, rp_analog_pkg::RST_HOLD + 2);
          n_err_o++;
          cur_err++;
        end
        report_test("reset_seq");
        rst_done = 1'b1;
      end
    end
  endtask

  // row h[2] checked against pins now, acq one cycle ago and triggers with the row
  task automatic check_row();
    int   sa;
    int   sb;
    logic ext_exp;
    sa = sum_f(h[2].gen.ch_a, h[2].pid.ch_a);
    sb = sum_f(h[2].gen.ch_b, h[2].pid.ch_b);
    check_val("dac_dat_o.ch_a", $unsigned(dac_dat_i.ch_a), code_f(sb));  // crossed
    check_val("dac_dat_o.ch_b", $unsigned(dac_dat_i.ch_b), code_f(sa));
    if (h[2].loop) begin
      check_val("acq_o.ch_a", h[1].acq.ch_a, sa[13:2]);  // same channel
      check_val("acq_o.ch_b", h[1].acq.ch_b, sb[13:2]);
    end else begin
      check_val("acq_o.ch_a", h[1].acq.ch_a, h[3].adc.ch_b[13:2]);
      check_val("acq_o.ch_b", h[1].acq.ch_b, h[3].adc.ch_a[13:2]);
    end
    ext_exp = (h[2].mode.sync && h[3].daisy_nz) ? 1'b0 : h[2].trig;
    check_val("trig_ext_o", h[2].trig_ext, ext_exp);
    check_val("trig_out_o", h[2].trig_out, h[2].mode.out_sel ? h[2].asg : h[2].scope);
    report_test(h[2].name);
  endtask

  always @(negedge adc_clk) begin
    snap_t s;
    s.vld      = row_vld_i;
    s.name     = row_name_i;
    s.adc      = adc_dat_i;
    s.gen      = gen_i;
    s.pid      = pid_i;
    s.loop     = digital_loop_i;
    s.trig     = trig_i;
    s.scope    = scope_trig_i;
    s.asg      = asg_trig_i;
    s.mode     = daisy_mode_i;
    s.daisy_nz = |daisy_dat_i;
    s.acq      = acq_i;
    s.trig_ext = trig_ext_i;
    s.trig_out = trig_out_i;
    h[3] = h[2];
    h[2] = h[1];
    h[1] = h[0];
    h[0] = s;
    check_reset();
    if (h[2].vld === 1'b1) check_row();
  end

endmodule

`default_nettype wire

// File: verif/tb_top.sv
////////////////////////////////////////
// directed rows then seeded random rows at one row per clock
// pll lock and delay-ready stay high throughout
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_top;

  typedef struct packed {
    logic [8*12-1:0]            name;
    rp_analog_pkg::adc_pair_t   adc;
    rp_analog_pkg::smp_pair_t   gen;
    rp_analog_pkg::smp_pair_t   pid;
    logic                       loop;
    logic [2:0]                 trg;    // trig, scope, asg
    rp_analog_pkg::daisy_mode_t mode;
    logic [15:0]                daisy;
  } row_t;

  row_t   rows [$];
  integer seed = 32'h450b;
  int     wd_limit;
  int     n_tests, n_fail, n_err;

  logic                             adc_clk = 1'b0;
  logic                             rst_n, pll_locked, idly_rdy;
  logic                             digital_loop, trig, scope_trig, asg_trig;
  logic                             row_vld;
  logic [8*12-1:0]                  row_name;
  rp_analog_pkg::adc_pair_t         adc_dat;
  rp_analog_pkg::smp_pair_t         gen, pid, dac_dat;
  rp_analog_pkg::daisy_mode_t       daisy_mode;
  logic [rp_analog_pkg::DAISY_DW-1:0] daisy_dat;
  rp_analog_pkg::acq_pair_t         acq;
  logic                             dac_reset, trig_ext, trig_out;

  rp_analog_top DUT (
    .adc_clk(adc_clk), .rst_n_i(rst_n), .pll_locked_i(pll_locked), .idly_rdy_i(idly_rdy),
    .adc_dat_i(adc_dat), .gen_i(gen), .pid_i(pid), .digital_loop_i(digital_loop),
    .trig_i(trig), .scope_trig_i(scope_trig), .asg_trig_i(asg_trig),
    .daisy_mode_i(daisy_mode), .daisy_dat_i(daisy_dat), .acq_o(acq), .dac_dat_o(dac_dat),
    .dac_reset_o(dac_reset), .trig_ext_o(trig_ext), .trig_out_o(trig_out)
  );

  tb_checker u_chk (
    .adc_clk(adc_clk), .rst_n_i(rst_n), .row_vld_i(row_vld), .row_name_i(row_name),
    .adc_dat_i(adc_dat), .gen_i(gen), .pid_i(pid), .digital_loop_i(digital_loop),
    .trig_i(trig), .scope_trig_i(scope_trig), .asg_trig_i(asg_trig),
    .daisy_mode_i(daisy_mode), .daisy_dat_i(daisy_dat), .acq_i(acq), .dac_dat_i(dac_dat),
    .dac_reset_i(dac_reset), .trig_ext_i(trig_ext), .trig_out_i(trig_out),
    .n_tests_o(n_tests), .n_fail_o(n_fail), .n_err_o(n_err)
  );

  initial begin
    forever #50 adc_clk = ~adc_clk;  // 100 ns period
  end

  task automatic add_row(input logic [8*12-1:0] nm, input rp_analog_pkg::adc_pair_t a,
                         input rp_analog_pkg::smp_pair_t g, input rp_analog_pkg::smp_pair_t p,
                         input logic lp, input logic [2:0] t,
                         input logic [rp_analog_pkg::DAISY_MODE_W-1:0] m,
                         input logic [15:0] d);
    row_t r;
    r = {nm, a, g, p, lp, t, m, d};
    rows.push_back(r);
  endtask

  task automatic drive_row(input row_t r, input logic vld);
    row_vld      <= vld;
    row_name     <= r.name;
    adc_dat      <= r.adc;
    gen          <= r.gen;
    pid          <= r.pid;
    digital_loop <= r.loop;
    {trig, scope_trig, asg_trig} <= r.trg;
    daisy_mode   <= r.mode;
    daisy_dat    <= r.daisy;
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic build_table();
    logic [31:0] r0, r1, r2, r3;
    add_row("adc_cross", {14'h3abc, 14'h0123}, {14'sd100, 14'sd0}, {-14'sd50, 14'sd7},
            1'b0, 3'b000, 3'b000, 16'h0);
    add_row("dac_inrange", {14'h0155, 14'h2aaa}, {14'sd1000, -14'sd3000},
            {14'sd2000, -14'sd1000}, 1'b0, 3'b000, 3'b000, 16'h0);
    add_row("dac_pos_sat", {14'h1fff, 14'h0}, {14'sd8000, 14'sd5000}, {14'sd500, 14'sd4000},
            1'b0, 3'b000, 3'b000, 16'h0);
    add_row("dac_neg_sat", {14'h0, 14'h3fff}, {-14'sd8000, -14'sd5000},
            {-14'sd500, -14'sd4000}, 1'b0, 3'b000, 3'b000, 16'h0);
    add_row("dac_edge", {14'h2000, 14'h1000}, {14'sd8191, -14'sd8192}, {14'sd0, 14'sd0},
            1'b0, 3'b000, 3'b000, 16'h0);
    add_row("loopback", {14'h0fff, 14'h3000}, {14'sd3000, -14'sd1234}, {-14'sd1234, 14'sd500},
            1'b1, 3'b000, 3'b000, 16'h0);
    add_row("loop_ovf", {14'h1234, 14'h0567}, {14'sd8191, -14'sd8192},
            {14'sd8191, -14'sd8192}, 1'b1, 3'b000, 3'b000, 16'h0);
    add_row("trig_pass", 28'h0, 28'h0, 28'h0, 1'b0, 3'b101, 3'b101, 16'h0);
    add_row("daisy_arm", 28'h0, 28'h0, 28'h0, 1'b0, 3'b110, 3'b001, 16'h0040);
    add_row("daisy_gate", 28'h0, 28'h0, 28'h0, 1'b0, 3'b100, 3'b001, 16'h0001);
    add_row("no_sync", 28'h0, 28'h0, 28'h0, 1'b0, 3'b111, 3'b100, 16'h8000);
    for (int k = 0; k < 8; k++) begin  // seeded random rows
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      add_row("random", r0[27:0], r1[27:0], r2[27:0], r3[0], r3[3:1], r3[6:4],
              r3[31:16] & {16{r3[7]}});
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    pll_locked = 1'b1;
    idly_rdy   = 1'b1;
    drive_row('0, 1'b0);
    build_table();
    repeat (3) @(posedge adc_clk);
    rst_n <= 1'b1;
    wait (dac_reset === 1'b0);  // core out of reset
    foreach (rows[i]) begin
      @(posedge adc_clk);
      drive_row(rows[i], 1'b1);
    end
    @(posedge adc_clk);
    drive_row('0, 1'b0);
    wait (n_tests == rows.size() + 1);  // reset sequence plus every row
    $display("tests %0d, failed %0d, errors %0d", n_tests, n_fail, n_err);
    if (n_fail == 0 && n_err == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // rows plus reset, hold, pipeline drain and margin
  initial begin
    #1;
    wd_limit = (rows.size() + 3 + rp_analog_pkg::RST_HOLD + 2 + 20) * 100;
    #(wd_limit);
    $display("watchdog expired at %0t, the run did not finish", $time);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
source/rp_analog_pkg.sv
source/core_reset_seq.sv
source/adc_frontend.sv
source/dac_mixer.sv
source/dac_backend.sv
source/rp_analog_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Makefile
# verilator build and run of the analog path testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -Mdir obj_dir -f compile.f
	@out="$$(./obj_dir/Vtb_top)"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
